//--- verilog/xv_pkg.sv
// shared sizes, types and enums for the bitmap video controller
// imported by every RTL module
`default_nettype none

package xv_pkg;

localparam int VRAM_AW        = 8;      // 256 words of video RAM
localparam int H_VISIBLE      = 16;     // pixels per line, one per clock
localparam int H_TOTAL        = 24;
localparam int HSYNC_START    = 18;
localparam int HSYNC_END      = 21;
localparam int V_VISIBLE      = 8;      // visible lines
localparam int V_TOTAL        = 12;
localparam int VSYNC_START    = 9;
localparam int VSYNC_END      = 10;
localparam int WORDS_PER_LINE = H_VISIBLE / 4;
localparam int H_W            = $clog2(H_TOTAL);
localparam int V_W            = $clog2(V_TOTAL);
localparam int INTR_VBLANK    = 0;      // interrupt bit numbers
localparam int INTR_HOST      = 1;

typedef logic [15:0]        word_t;     // four pixels, msb nibble shown first
typedef logic [VRAM_AW-1:0] addr_t;
typedef logic [3:0]         pixel_t;    // colour index
typedef logic [H_W-1:0]     hcount_t;
typedef logic [V_W-1:0]     vcount_t;

// host bus register numbers
typedef enum logic [3:0] {
    SYS_CTRL = 4'h0,
    INTR_CLR = 4'h1,
    WR_ADDR  = 4'h2,
    WR_INCR  = 4'h3,
    WR_DATA  = 4'h4,
    RD_ADDR  = 4'h5,
    RD_DATA  = 4'h6,
    VID_BASE = 4'h7
} reg_num_t;

typedef enum logic [1:0] {
    IDLE,
    VRAM_WR,
    VRAM_RD
} ri_state_t;

endpackage
`default_nettype wire

//--- verilog/reg_interface.sv
// host register file: byte accesses on the 8-bit bus become 16-bit register writes
// and video RAM word reads and writes; also holds the interrupt mask and frame base
`default_nettype none
`timescale 1ns/1ps

module reg_interface(
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_n_i,     // access strobe, active low
    input  wire logic           bus_rd_nwr_i,   // 1 = read, 0 = write
    input  wire logic [3:0]     bus_reg_num_i,
    input  wire logic           bus_bytesel_i,  // 0 = even (high) byte
    input  wire logic [7:0]     bus_data_i,
    input  wire logic           regs_ack_i,     // one clock, ends a vram request
    input  wire xv_pkg::word_t  vram_data_i,
    input  wire logic [3:0]     intr_status_i,
    output logic      [7:0]     bus_data_o,
    output logic                regs_sel_o,
    output logic                regs_wr_o,
    output xv_pkg::addr_t       regs_addr_o,
    output xv_pkg::word_t       regs_data_o,
    output xv_pkg::addr_t       vid_base_o,
    output logic      [3:0]     intr_mask_o,
    output logic      [3:0]     intr_clear_o,   // one clock strobe
    output logic                host_intr_o     // one clock strobe
);
import xv_pkg::*;

ri_state_t  state;
reg_num_t   reg_num;
logic       bus_wr;         // write access this clock
logic       bus_rd;         // read access this clock
logic       commit;         // odd byte write, word complete
logic [7:0] hold_byte;      // even byte waiting for its partner
word_t      wr_word;
word_t      rd_word;        // value of the addressed register
addr_t      wr_addr;
addr_t      wr_incr;
addr_t      rd_addr;
word_t      rd_data;        // prefetched word at rd_addr

assign reg_num = reg_num_t'(bus_reg_num_i);
assign bus_wr  = !bus_cs_n_i && !bus_rd_nwr_i;
assign bus_rd  = !bus_cs_n_i && bus_rd_nwr_i;
assign commit  = bus_wr && bus_bytesel_i;
assign wr_word = {hold_byte, bus_data_i};

// register read mux
always_comb begin
    case (reg_num)
        SYS_CTRL: rd_word = {4'h0, intr_status_i, 4'h0, intr_mask_o};
        WR_ADDR:  rd_word = word_t'(wr_addr);
        WR_INCR:  rd_word = word_t'(wr_incr);
        RD_ADDR:  rd_word = word_t'(rd_addr);
        RD_DATA:  rd_word = rd_data;
        VID_BASE: rd_word = word_t'(vid_base_o);
        default:  rd_word = '0;     // write-only or unused
    endcase
end

// data path, no reset needed
always_ff @(posedge clk) begin
    if (bus_wr && !bus_bytesel_i) begin
        hold_byte <= bus_data_i;
    end
    if (bus_rd) begin
        bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];   // held until next read
    end
    if (commit && reg_num == WR_DATA) begin
        regs_data_o <= wr_word;
    end
    if (state == VRAM_RD && regs_ack_i) begin
        rd_data <= vram_data_i;     // prefetch lands
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        state        <= IDLE;
        regs_sel_o   <= 1'b0;
        regs_wr_o    <= 1'b0;
        regs_addr_o  <= '0;
        wr_addr      <= '0;
        wr_incr      <= '0;
        rd_addr      <= '0;
        vid_base_o   <= '0;
        intr_mask_o  <= '0;
        intr_clear_o <= '0;
        host_intr_o  <= 1'b0;
    end else begin
        intr_clear_o <= '0;
        host_intr_o  <= 1'b0;
        // finish outstanding vram request
        if (state != IDLE && regs_ack_i) begin
            regs_sel_o <= 1'b0;
            state      <= IDLE;
        end
        if (commit) begin
            case (reg_num)
                SYS_CTRL: intr_mask_o <= wr_word[3:0];
                INTR_CLR: begin
                    intr_clear_o <= wr_word[3:0];
                    host_intr_o  <= wr_word[4];     // host raises its own interrupt
                end
                WR_ADDR:  wr_addr <= wr_word[VRAM_AW-1:0];
                WR_INCR:  wr_incr <= wr_word[VRAM_AW-1:0];
                WR_DATA: begin
                    regs_sel_o  <= 1'b1;
                    regs_wr_o   <= 1'b1;
                    regs_addr_o <= wr_addr;
                    wr_addr     <= wr_addr + wr_incr;   // post increment
                    state       <= VRAM_WR;
                end
                RD_ADDR: begin
                    rd_addr     <= wr_word[VRAM_AW-1:0];
                    regs_sel_o  <= 1'b1;
                    regs_wr_o   <= 1'b0;
                    regs_addr_o <= wr_word[VRAM_AW-1:0];
                    state       <= VRAM_RD;
                end
                VID_BASE: vid_base_o <= wr_word[VRAM_AW-1:0];
                default: ;
            endcase
        end
        // odd byte read of RD_DATA steps to the next word
        if (bus_rd && bus_bytesel_i && reg_num == RD_DATA) begin
            rd_addr     <= rd_addr + 1'b1;
            regs_sel_o  <= 1'b1;
            regs_wr_o   <= 1'b0;
            regs_addr_o <= rd_addr + 1'b1;
            state       <= VRAM_RD;
        end
    end
end

endmodule
`default_nettype wire

//--- verilog/vram_arb.sv
// single-port video RAM shared by the raster generator and the register interface
// raster fetches always win, register requests take the free clocks
`default_nettype none
`timescale 1ns/1ps

module vram_arb(
    input  wire logic           clk,
    input  wire logic           vgen_sel_i,     // raster fetch, never waits
    input  wire xv_pkg::addr_t  vgen_addr_i,
    input  wire logic           regs_sel_i,     // held until regs_ack_o
    input  wire logic           regs_wr_i,
    input  wire xv_pkg::addr_t  regs_addr_i,
    input  wire xv_pkg::word_t  regs_data_i,
    output logic                regs_ack_o,
    output xv_pkg::word_t       vram_data_o     // registered read data
);
import xv_pkg::*;

word_t  mem [2**VRAM_AW];   // 256 words

logic   grant_regs;         // register port owns the RAM this clock
logic   port_we;
addr_t  port_addr;

always_comb begin
    // skip the ack clock so one request gets one access
    grant_regs = regs_sel_i && !vgen_sel_i && !regs_ack_o;
    port_we    = grant_regs && regs_wr_i;
    port_addr  = vgen_sel_i ? vgen_addr_i : regs_addr_i;
end

always_ff @(posedge clk) begin
    if (port_we) begin
        mem[port_addr] <= regs_data_i;
    end
    vram_data_o <= mem[port_addr];  // read old data on a write clock
end

// ack pulse, clears itself after one clock
always_ff @(posedge clk) begin
    regs_ack_o <= grant_regs;
end

endmodule
`default_nettype wire

//--- verilog/video_gen.sv
// raster generator: pixel and line counters, sync, video RAM fetch and nibble shifter
// outputs leave 2 clocks after the counters; also signals the vertical-blank interrupt
`default_nettype none
`timescale 1ns/1ps

module video_gen(
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire xv_pkg::addr_t  vid_base_i,     // frame start, taken at frame end
    input  wire xv_pkg::word_t  vram_data_i,    // valid the clock after vram_sel_o
    output logic                vram_sel_o,
    output xv_pkg::addr_t       vram_addr_o,
    output xv_pkg::pixel_t      pixel_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o,
    output logic      [3:0]     intr_signal_o
);
import xv_pkg::*;

hcount_t    h_count;
vcount_t    v_count;
logic       h_last;
logic       v_last;
logic       visible_0;      // stage 0, counters
logic       hsync_0;
logic       vsync_0;
logic       fetch_1;        // stage 1, RAM data arriving
logic       de_1;
logic       hsync_1;
logic       vsync_1;
addr_t      fetch_addr;     // next word of the frame
word_t      shifter;        // stage 2, msb nibble on screen

assign h_last     = (h_count == hcount_t'(H_TOTAL - 1));
assign v_last     = (v_count == vcount_t'(V_TOTAL - 1));
assign visible_0  = (h_count < hcount_t'(H_VISIBLE)) && (v_count < vcount_t'(V_VISIBLE));
assign hsync_0    = (h_count >= hcount_t'(HSYNC_START)) && (h_count < hcount_t'(HSYNC_END));
assign vsync_0    = (v_count >= vcount_t'(VSYNC_START)) && (v_count < vcount_t'(VSYNC_END));
assign vram_sel_o = visible_0 && (h_count[1:0] == 2'b00);  // one word per 4 pixels
assign vram_addr_o = fetch_addr;
assign pixel_o    = shifter[15:12];

// counters; words are fetched in order so the address just counts
always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count    <= '0;
        v_count    <= '0;
        fetch_addr <= '0;
    end else begin
        h_count <= h_last ? '0 : h_count + 1'b1;
        if (h_last) begin
            v_count <= v_last ? '0 : v_count + 1'b1;
        end
        if (h_last && v_last) begin
            fetch_addr <= vid_base_i;   // base + line * WORDS_PER_LINE + x/4
        end else if (vram_sel_o) begin
            fetch_addr <= fetch_addr + 1'b1;
        end
    end
end

// sync and enable delayed to line up with the shifter
always_ff @(posedge clk) begin
    if (reset_i) begin
        fetch_1       <= 1'b0;
        de_1          <= 1'b0;
        hsync_1       <= 1'b0;
        vsync_1       <= 1'b0;
        dv_de_o       <= 1'b0;
        hsync_o       <= 1'b0;
        vsync_o       <= 1'b0;
        intr_signal_o <= '0;
    end else begin
        fetch_1 <= vram_sel_o;
        de_1    <= visible_0;
        hsync_1 <= hsync_0;
        vsync_1 <= vsync_0;
        dv_de_o <= de_1;
        hsync_o <= hsync_1;
        vsync_o <= vsync_1;
        intr_signal_o <= '0;
        if (h_last && v_count == vcount_t'(V_VISIBLE - 1)) begin
            intr_signal_o[INTR_VBLANK] <= 1'b1;    // entering first blank line
        end
    end
end

// nibble shifter, zeros fill in so blanking shows index 0
always_ff @(posedge clk) begin
    if (fetch_1) begin
        shifter <= vram_data_i;
    end else begin
        shifter <= {shifter[11:0], 4'h0};
    end
end

endmodule
`default_nettype wire

//--- verilog/video_main.sv
// top level of the bitmap video controller: host register bus, video RAM, raster
// generator and the interrupt status shared between them
`default_nettype none
`timescale 1ns/1ps

module video_main(
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_n_i,     // register select, active low
    input  wire logic           bus_rd_nwr_i,   // 1 = read
    input  wire logic [3:0]     bus_reg_num_i,
    input  wire logic           bus_bytesel_i,  // 0 = even byte
    input  wire logic [7:0]     bus_data_i,
    output logic      [7:0]     bus_data_o,
    output logic                bus_intr_o,     // host interrupt strobe
    output xv_pkg::pixel_t      pixel_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o
);
import xv_pkg::*;

logic       vgen_sel;           // raster fetch request
addr_t      vgen_addr;
word_t      vram_data;          // RAM read data for both users
logic       regs_sel;
logic       regs_wr;
logic       regs_ack;
addr_t      regs_addr;
word_t      regs_data;
addr_t      vid_base;
logic [3:0] intr_mask;          // enabled interrupts
logic [3:0] intr_status;        // pending interrupts
logic [3:0] intr_clear;         // host clear strobe
logic [3:0] vgen_intr;
logic [3:0] intr_signal;        // all sources merged
logic       host_intr;

always_comb begin
    intr_signal            = vgen_intr;
    intr_signal[INTR_HOST] = vgen_intr[INTR_HOST] | host_intr;
end

reg_interface reg_interface(
    .clk(clk),
    .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i),
    .bus_rd_nwr_i(bus_rd_nwr_i),
    .bus_reg_num_i(bus_reg_num_i),
    .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i),
    .regs_ack_i(regs_ack),
    .vram_data_i(vram_data),
    .intr_status_i(intr_status),
    .bus_data_o(bus_data_o),
    .regs_sel_o(regs_sel),
    .regs_wr_o(regs_wr),
    .regs_addr_o(regs_addr),
    .regs_data_o(regs_data),
    .vid_base_o(vid_base),
    .intr_mask_o(intr_mask),
    .intr_clear_o(intr_clear),
    .host_intr_o(host_intr)
);

vram_arb vram_arb(
    .clk(clk),
    .vgen_sel_i(vgen_sel),
    .vgen_addr_i(vgen_addr),
    .regs_sel_i(regs_sel),
    .regs_wr_i(regs_wr),
    .regs_addr_i(regs_addr),
    .regs_data_i(regs_data),
    .regs_ack_o(regs_ack),
    .vram_data_o(vram_data)
);

video_gen video_gen(
    .clk(clk),
    .reset_i(reset_i),
    .vid_base_i(vid_base),
    .vram_data_i(vram_data),
    .vram_sel_o(vgen_sel),
    .vram_addr_o(vgen_addr),
    .pixel_o(pixel_o),
    .hsync_o(hsync_o),
    .vsync_o(vsync_o),
    .dv_de_o(dv_de_o),
    .intr_signal_o(vgen_intr)
);

// interrupt status and host strobe
always_ff @(posedge clk) begin
    if (reset_i) begin
        bus_intr_o  <= 1'b0;
        intr_status <= '0;
    end else begin
        // only new, enabled interrupts reach the host
        bus_intr_o  <= |(intr_signal & intr_mask & ~intr_status);
        intr_status <= (intr_status | intr_signal) & ~intr_clear;
    end
end

endmodule
`default_nettype wire

//--- testbench/video_main_checker.sv
// concurrent assertions on video RAM arbitration, sync and host interrupt rules
// bound into video_main below
`default_nettype none
`timescale 1ns/1ps

module video_main_checker(
    input wire logic clk,
    input wire logic reset_i,
    input wire logic regs_sel_i,    // register port request
    input wire logic regs_ack_i,
    input wire logic bus_intr_i,
    input wire logic dv_de_i,
    input wire logic vsync_i
);

int unsigned pending;   // clocks a request has waited so far

always_ff @(posedge clk) begin
    if (reset_i || !regs_sel_i || regs_ack_i) begin
        pending <= 0;
    end else begin
        pending <= pending + 1;
    end
end

ack_needs_sel: assert property (@(posedge clk) disable iff (reset_i)
    regs_ack_i |-> regs_sel_i) else $error("regs_ack seen with no request");

// raster steals at most one clock
ack_in_time: assert property (@(posedge clk) disable iff (reset_i)
    pending < 3) else $error("register request waited more than 3 clocks");

intr_one_clock: assert property (@(posedge clk) disable iff (reset_i)
    bus_intr_i |=> !bus_intr_i) else $error("bus_intr high for two clocks");

no_de_in_vsync: assert property (@(posedge clk) disable iff (reset_i)
    !(dv_de_i && vsync_i)) else $error("display enable during vertical sync");

endmodule

bind video_main video_main_checker rule_check(
    .clk(clk),
    .reset_i(reset_i),
    .regs_sel_i(regs_sel),
    .regs_ack_i(regs_ack),
    .bus_intr_i(bus_intr_o),
    .dv_de_i(dv_de_o),
    .vsync_i(vsync_o)
);
`default_nettype wire

//--- testbench/video_main_tb.sv
// directed tests for the bitmap video controller over its host register bus
// covers video RAM access, raster output, sync shape and both interrupts
`default_nettype none
`timescale 1ns/1ps

module video_main_tb;
import xv_pkg::*;

localparam int FRAME_CLKS = H_TOTAL * V_TOTAL;
localparam int WAIT_LIMIT = 4 * FRAME_CLKS;    // clocks before a wait gives up

logic           clk = 1'b0;
logic           reset;
logic           bus_cs_n;
logic           bus_rd_nwr;
logic [3:0]     bus_reg_num;
logic           bus_bytesel;
logic [7:0]     bus_data_in;
logic [7:0]     bus_data_out;
logic           bus_intr;
pixel_t         pixel;
logic           hsync;
logic           vsync;
logic           dv_de;

word_t          vram_model [2**VRAM_AW];    // expected RAM contents
logic [15:0]    rng;                        // xorshift state
int             intr_pulses = 0;            // host interrupt strobes seen

video_main UUT(
    .clk(clk),
    .reset_i(reset),
    .bus_cs_n_i(bus_cs_n),
    .bus_rd_nwr_i(bus_rd_nwr),
    .bus_reg_num_i(bus_reg_num),
    .bus_bytesel_i(bus_bytesel),
    .bus_data_i(bus_data_in),
    .bus_data_o(bus_data_out),
    .bus_intr_o(bus_intr),
    .pixel_o(pixel),
    .hsync_o(hsync),
    .vsync_o(vsync),
    .dv_de_o(dv_de)
);

always #10 clk = ~clk;  // 20 ns period

// sampled mid cycle, away from the DUT edge
always @(negedge clk) begin
    if (bus_intr === 1'b1) begin
        intr_pulses <= intr_pulses + 1;
    end
end

function automatic logic [15:0] xorshift16(input logic [15:0] x);
    logic [15:0] s;
    s = x;
    s = s ^ (s << 7);
    s = s ^ (s >> 9);
    s = s ^ (s << 8);
    return s;
endfunction

// background contents, every address bit shows up
function automatic word_t fill_pattern(input addr_t a);
    return {~a, a ^ 8'hA5};
endfunction

task automatic fail_now(input string what);
    $display("[ERROR] %0t %s", $time, what);
    $display("Finished with errors");
    $fatal(1);
endtask

task automatic check_value(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
    assert (actual === expected) else begin
        $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
        $display("Finished with errors");
        $fatal(1);
    end
endtask

// one bus clock, then the four idle clocks the host must leave
task automatic bus_access(input logic rd, input reg_num_t num, input logic bytesel,
                          input logic [7:0] data, output logic [7:0] rdata);
    bus_cs_n    = 1'b0;
    bus_rd_nwr  = rd;
    bus_reg_num = num;
    bus_bytesel = bytesel;
    bus_data_in = data;
    @(posedge clk);
    #1;
    bus_cs_n = 1'b1;
    rdata    = bus_data_out;    // registered at the access edge
    repeat (4) @(posedge clk);
    #1;
endtask

task automatic bus_write_word(input reg_num_t num, input word_t value);
    logic [7:0] ignored;
    bus_access(1'b0, num, 1'b0, value[15:8], ignored);     // even byte held
    bus_access(1'b0, num, 1'b1, value[7:0], ignored);      // odd byte commits
endtask

task automatic bus_read_word(input reg_num_t num, output word_t value);
    logic [7:0] hi;
    logic [7:0] lo;
    bus_access(1'b1, num, 1'b0, 8'h00, hi);
    bus_access(1'b1, num, 1'b1, 8'h00, lo);
    value = {hi, lo};
endtask

task automatic wait_vsync_fall();
    int n;
    n = 0;
    while (vsync !== 1'b1) begin
        @(posedge clk);
        #1;
        n++;
        if (n > WAIT_LIMIT) fail_now("timeout waiting for vsync_o to rise");
    end
    n = 0;
    while (vsync !== 1'b0) begin
        @(posedge clk);
        #1;
        n++;
        if (n > WAIT_LIMIT) fail_now("timeout waiting for vsync_o to fall");
    end
endtask

task automatic reset_state();
    word_t value;
    check_value("hsync_o", 16'd0, 16'(hsync));
    check_value("vsync_o", 16'd0, 16'(vsync));
    check_value("dv_de_o", 16'd0, 16'(dv_de));
    check_value("bus_intr_o", 16'd0, 16'(bus_intr));
    bus_read_word(SYS_CTRL, value);
    check_value("SYS_CTRL", 16'd0, value);
endtask

task automatic fill_vram();
    int a;
    bus_write_word(WR_INCR, 16'd1);
    bus_write_word(WR_ADDR, 16'd0);
    for (a = 0; a < 2**VRAM_AW; a++) begin
        vram_model[addr_t'(a)] = fill_pattern(addr_t'(a));
        bus_write_word(WR_DATA, vram_model[addr_t'(a)]);
    end
endtask

// stride 3 writes, stride 1 reads, raster running alongside
task automatic stride_access();
    int    i;
    int    n;
    addr_t start;
    addr_t a;
    word_t value;
    start = 8'h20;
    n = 0;
    while (dv_de !== 1'b1) begin
        @(posedge clk);
        #1;
        n++;
        if (n > WAIT_LIMIT) fail_now("timeout waiting for active video");
    end
    bus_write_word(WR_ADDR, 16'(start));
    bus_write_word(WR_INCR, 16'd3);
    for (i = 0; i < 12; i++) begin
        rng = xorshift16(rng);
        a = start + addr_t'(3 * i);
        vram_model[a] = rng;
        bus_write_word(WR_DATA, rng);
    end
    bus_write_word(RD_ADDR, 16'(start));   // starts the prefetch
    for (i = 0; i < 12; i++) begin
        a = start + addr_t'(i);
        bus_read_word(RD_DATA, value);
        check_value($sformatf("RD_DATA at %h", a), vram_model[a], value);
    end
endtask

task automatic raster_frame();
    int     i;
    int     k;
    word_t  w;
    pixel_t expected;
    bus_write_word(WR_INCR, 16'd1);
    bus_write_word(WR_ADDR, 16'd64);
    for (i = 0; i < 32; i++) begin
        rng = xorshift16(rng);
        vram_model[addr_t'(64 + i)] = rng;
        bus_write_word(WR_DATA, rng);
    end
    bus_write_word(VID_BASE, 16'd64);
    wait_vsync_fall();
    k = 0;
    for (i = 0; i < FRAME_CLKS; i++) begin
        if (dv_de === 1'b1) begin
            w = vram_model[addr_t'(64 + k / 4)];
            expected = pixel_t'(w >> (4 * (3 - k % 4)));   // msb nibble first
            check_value("pixel_o", 16'(expected), 16'(pixel));
            k++;
        end
        @(posedge clk);
        #1;
    end
    check_value("dv_de_o clocks per frame", 16'(H_VISIBLE * V_VISIBLE), 16'(k));
endtask

task automatic sync_shape();
    int i;
    int run;
    int hsync_runs;
    int vsync_clks;
    wait_vsync_fall();
    run = 0;
    hsync_runs = 0;
    vsync_clks = 0;
    for (i = 0; i < FRAME_CLKS; i++) begin
        check_value("dv_de_o during vsync_o", 16'd0, 16'(dv_de & vsync));
        if (hsync === 1'b1) begin
            run++;
        end else if (run != 0) begin
            check_value("hsync_o width", 16'(HSYNC_END - HSYNC_START), 16'(run));
            hsync_runs++;
            run = 0;
        end
        if (vsync === 1'b1) begin
            vsync_clks++;
        end
        @(posedge clk);
        #1;
    end
    check_value("hsync_o pulses per frame", 16'(V_TOTAL), 16'(hsync_runs));
    check_value("vsync_o clocks per frame", 16'((VSYNC_END - VSYNC_START) * H_TOTAL),
                16'(vsync_clks));
endtask

task automatic vblank_interrupt();
    int    start;
    word_t value;
    start = intr_pulses;    // mask still 0 from reset
    repeat (FRAME_CLKS) @(posedge clk);
    #1;
    check_value("bus_intr_o pulses, mask 0", 16'd0, 16'(intr_pulses - start));
    bus_write_word(SYS_CTRL, 16'h0001);
    wait_vsync_fall();      // well clear of the next vblank
    bus_write_word(INTR_CLR, 16'h0001);
    start = intr_pulses;
    repeat (FRAME_CLKS) @(posedge clk);
    #1;
    check_value("bus_intr_o pulses per frame", 16'd1, 16'(intr_pulses - start));
    bus_read_word(SYS_CTRL, value);
    check_value("SYS_CTRL", 16'h0101, value);
    bus_write_word(INTR_CLR, 16'h0001);
    bus_read_word(SYS_CTRL, value);
    check_value("SYS_CTRL", 16'h0001, value);
endtask

task automatic host_interrupt();
    int    start;
    int    n;
    word_t value;
    bus_write_word(SYS_CTRL, 16'h0002);     // host bit only
    start = intr_pulses;
    bus_write_word(INTR_CLR, 16'h0010);
    n = 0;
    while (intr_pulses == start) begin
        @(posedge clk);
        #1;
        n++;
        if (n > WAIT_LIMIT) fail_now("no bus_intr_o after host interrupt write");
    end
    bus_read_word(SYS_CTRL, value);
    check_value("SYS_CTRL status bit 1", 16'd1, 16'(value[9]));
    check_value("SYS_CTRL mask", 16'h0002, 16'(value[7:0]));
endtask

initial begin
    reset       = 1'b1;
    bus_cs_n    = 1'b1;
    bus_rd_nwr  = 1'b0;
    bus_reg_num = 4'h0;
    bus_bytesel = 1'b0;
    bus_data_in = 8'h00;
    rng         = 16'd45403;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    reset_state();
    fill_vram();
    stride_access();
    raster_frame();
    sync_shape();
    vblank_interrupt();
    host_interrupt();
    $display("Finished with no errors");
    $finish;
end

endmodule
`default_nettype wire

//--- build.f
verilog/xv_pkg.sv
verilog/reg_interface.sv
verilog/vram_arb.sv
verilog/video_gen.sv
verilog/video_main.sv
testbench/video_main_checker.sv
testbench/video_main_tb.sv

//--- Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := video_main_tb
FILELIST  := build.f

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Finished with no errors
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
